// ==== common/lsu_fwd_pkg.sv ====
// shared definitions for the store-to-load forwarding path
//   widths of address, data and byte enables
//   access size encoding and its byte-enable mapping

`default_nettype none

package lsu_fwd_pkg;

   // ********************
   // widths
   // ********************
   localparam int addr_w     = 32;
   localparam int data_w     = 32;
   localparam int word_bytes = 4;
   localparam int word_lsb   = 2;   // word compare starts here

   // access size of a memory operation
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } ls_size_e;

   typedef logic [word_bytes-1:0]   byteen_t;       // one bit per byte of a word
   typedef logic [2*word_bytes-1:0] byteen_ext_t;   // enables across lo and hi word
   typedef logic [2*data_w-1:0]     data_ext_t;     // data across lo and hi word

   // unshifted byte enables for an access size
   function automatic byteen_t size_byteen(input ls_size_e size);
      case (size)
         size_byte: size_byteen = 4'b0001;
         size_half: size_byteen = 4'b0011;
         size_word: size_byteen = 4'b1111;
         default:   size_byteen = 4'b0000;   // unused encoding enables nothing
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== common/lsu_stage_if.sv ====
// one pipeline stage's view of a memory operation
//   src drives the view, snk reads it

`default_nettype none

interface lsu_stage_if;
   import lsu_fwd_pkg::*;

   logic              valid;
   logic              store;        // low for a load
   logic [addr_w-1:0] addr;         // first byte
   logic [addr_w-1:0] end_addr;     // last byte
   byteen_ext_t       byteen_ext;   // enables shifted by byte offset
   data_ext_t         data_ext;     // store data shifted by byte offset

   modport src (
      output valid,
      output store,
      output addr,
      output end_addr,
      output byteen_ext,
      output data_ext
   );

   modport snk (
      input valid,
      input store,
      input addr,
      input end_addr,
      input byteen_ext,
      input data_ext
   );

endinterface

`default_nettype wire

// ==== lsu_fwd/lsu_stage_pipe.sv ====
// operation pipe of the forwarding path
//   builds the dc2 view from the incoming operation
//   registers that view through dc3, dc4 and dc5

`default_nettype none

module lsu_stage_pipe (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             op_valid,
   input  logic                             op_store,
   input  lsu_fwd_pkg::ls_size_e            op_size,
   input  logic [lsu_fwd_pkg::addr_w-1:0]   op_addr,
   input  logic [lsu_fwd_pkg::data_w-1:0]   op_wdata,
   lsu_stage_if.src                         dc2,
   lsu_stage_if.src                         dc3,
   lsu_stage_if.src                         dc4,
   lsu_stage_if.src                         dc5
);
   import lsu_fwd_pkg::*;

   byteen_t    byteen;
   logic [1:0] size_m1;   // access size in bytes minus one

   // ********************
   // dc2 view
   // ********************
   assign byteen = size_byteen(op_size);

   always_comb begin
      case (op_size)
         size_byte: size_m1 = 2'd0;
         size_half: size_m1 = 2'd1;
         size_word: size_m1 = 2'd3;
         default:   size_m1 = 2'd0;
      endcase
   end

   assign dc2.valid      = op_valid;
   assign dc2.store      = op_store;
   assign dc2.addr       = op_addr;
   assign dc2.end_addr   = op_addr + {{(addr_w-2){1'b0}}, size_m1};
   // a misaligned access spills into the hi word
   assign dc2.byteen_ext = {{word_bytes{1'b0}}, byteen} << op_addr[word_lsb-1:0];
   assign dc2.data_ext   = {{data_w{1'b0}}, op_wdata} << {op_addr[word_lsb-1:0], 3'b000};

   // ********************
   // dc3 to dc5
   // ********************
   always_ff @(posedge clk) begin
      if (reset) begin
         dc3.valid <= 1'b0;
         dc4.valid <= 1'b0;
         dc5.valid <= 1'b0;
      end else begin
         dc3.valid <= dc2.valid;
         dc4.valid <= dc3.valid;
         dc5.valid <= dc4.valid;
      end
   end

   always_ff @(posedge clk) begin
      dc3.store      <= dc2.store;
      dc3.addr       <= dc2.addr;
      dc3.end_addr   <= dc2.end_addr;
      dc3.byteen_ext <= dc2.byteen_ext;
      dc3.data_ext   <= dc2.data_ext;

      dc4.store      <= dc3.store;
      dc4.addr       <= dc3.addr;
      dc4.end_addr   <= dc3.end_addr;
      dc4.byteen_ext <= dc3.byteen_ext;
      dc4.data_ext   <= dc3.data_ext;

      dc5.store      <= dc4.store;
      dc5.addr       <= dc4.addr;
      dc5.end_addr   <= dc4.end_addr;
      dc5.byteen_ext <= dc4.byteen_ext;
      dc5.data_ext   <= dc4.data_ext;
   end

endmodule

`default_nettype wire

// ==== lsu_fwd/lsu_fwd_match.sv ====
// byte match of the dc2 load against one older store stage
//   word address compare of start and end addresses
//   per-byte hits and forwarded bytes for the load's lo and hi words

`default_nettype none

module lsu_fwd_match (
   lsu_stage_if.snk                         ld,
   lsu_stage_if.snk                         st,
   output lsu_fwd_pkg::byteen_t             hit_lo,
   output lsu_fwd_pkg::byteen_t             hit_hi,
   output logic [lsu_fwd_pkg::data_w-1:0]   data_lo,
   output logic [lsu_fwd_pkg::data_w-1:0]   data_hi
);
   import lsu_fwd_pkg::*;

   logic    qual;                  // valid load against valid store
   logic    addr_lo_lo, addr_lo_hi, addr_hi_lo, addr_hi_hi;
   byteen_t ld_be_lo, ld_be_hi;
   byteen_t st_be_lo, st_be_hi;
   byteen_t byte_lo_lo, byte_lo_hi, byte_hi_lo, byte_hi_hi;

   assign qual = ld.valid & ~ld.store & st.valid & st.store;

   // first half of the name is the store word, second half the load word
   assign addr_lo_lo = qual & (ld.addr[addr_w-1:word_lsb]     == st.addr[addr_w-1:word_lsb]);
   assign addr_lo_hi = qual & (ld.end_addr[addr_w-1:word_lsb] == st.addr[addr_w-1:word_lsb]);
   assign addr_hi_lo = qual & (ld.addr[addr_w-1:word_lsb]     == st.end_addr[addr_w-1:word_lsb]);
   assign addr_hi_hi = qual & (ld.end_addr[addr_w-1:word_lsb] == st.end_addr[addr_w-1:word_lsb]);

   assign ld_be_lo = ld.byteen_ext[word_bytes-1:0];
   assign ld_be_hi = ld.byteen_ext[2*word_bytes-1:word_bytes];
   assign st_be_lo = st.byteen_ext[word_bytes-1:0];
   assign st_be_hi = st.byteen_ext[2*word_bytes-1:word_bytes];

   // a byte hits only where both sides enable it
   assign byte_lo_lo = {word_bytes{addr_lo_lo}} & st_be_lo & ld_be_lo;
   assign byte_lo_hi = {word_bytes{addr_lo_hi}} & st_be_lo & ld_be_hi;
   assign byte_hi_lo = {word_bytes{addr_hi_lo}} & st_be_hi & ld_be_lo;
   assign byte_hi_hi = {word_bytes{addr_hi_hi}} & st_be_hi & ld_be_hi;

   assign hit_lo = byte_lo_lo | byte_hi_lo;
   assign hit_hi = byte_lo_hi | byte_hi_hi;

   // ********************
   // forwarded bytes
   // ********************
   always_comb begin
      data_lo = '0;
      data_hi = '0;
      for (int i = 0; i < word_bytes; i++) begin
         // store lo and hi enables never overlap, so at most one source per byte
         if (byte_lo_lo[i]) data_lo[8*i +: 8] = st.data_ext[8*i +: 8];
         if (byte_hi_lo[i]) data_lo[8*i +: 8] = st.data_ext[data_w + 8*i +: 8];
         if (byte_lo_hi[i]) data_hi[8*i +: 8] = st.data_ext[8*i +: 8];
         if (byte_hi_hi[i]) data_hi[8*i +: 8] = st.data_ext[data_w + 8*i +: 8];
      end
   end

endmodule

`default_nettype wire

// ==== lsu_fwd/lsu_fwd_merge.sv ====
// merge of forwarded bytes from dc3, dc4 and dc5
//   youngest stage wins per byte, hit any and full hit
//   alignment to bit 0 and the dc3 result register

`default_nettype none

module lsu_fwd_merge (
   input  logic                             clk,
   input  logic                             reset,
   lsu_stage_if.snk                         ld,
   input  lsu_fwd_pkg::byteen_t             hit_lo [3],    // index 0 is dc3
   input  lsu_fwd_pkg::byteen_t             hit_hi [3],
   input  logic [lsu_fwd_pkg::data_w-1:0]   data_lo [3],
   input  logic [lsu_fwd_pkg::data_w-1:0]   data_hi [3],
   output logic                             ld_valid,
   output logic                             ld_hit_any,
   output logic                             ld_full_hit,
   output logic [lsu_fwd_pkg::data_w-1:0]   ld_data
);
   import lsu_fwd_pkg::*;

   logic                load_dc2;
   byteen_t             byte_hit_lo, byte_hit_hi;
   logic [data_w-1:0]   fwd_lo, fwd_hi;
   data_ext_t           fwd_shift;
   logic                hit_any_dc2, full_hit_dc2;

   assign load_dc2 = ld.valid & ~ld.store;

   // ********************
   // per-byte priority
   // ********************
   always_comb begin
      byte_hit_lo = '0;
      byte_hit_hi = '0;
      fwd_lo      = '0;
      fwd_hi      = '0;
      // walk oldest to youngest so dc3 is written last
      for (int s = 2; s >= 0; s--) begin
         for (int i = 0; i < word_bytes; i++) begin
            if (hit_lo[s][i]) fwd_lo[8*i +: 8] = data_lo[s][8*i +: 8];
            if (hit_hi[s][i]) fwd_hi[8*i +: 8] = data_hi[s][8*i +: 8];
         end
         byte_hit_lo = byte_hit_lo | hit_lo[s];
         byte_hit_hi = byte_hit_hi | hit_hi[s];
      end
   end

   assign hit_any_dc2  = (|byte_hit_lo) | (|byte_hit_hi);

   // every enabled load byte must be covered
   assign full_hit_dc2 = load_dc2 &
                         (&(byte_hit_lo | ~ld.byteen_ext[word_bytes-1:0])) &
                         (&(byte_hit_hi | ~ld.byteen_ext[2*word_bytes-1:word_bytes]));

   assign fwd_shift = {fwd_hi, fwd_lo} >> {ld.addr[word_lsb-1:0], 3'b000};

   // ********************
   // dc3 result
   // ********************
   always_ff @(posedge clk) begin
      if (reset) begin
         ld_valid    <= 1'b0;
         ld_hit_any  <= 1'b0;
         ld_full_hit <= 1'b0;
         ld_data     <= '0;
      end else begin
         ld_valid    <= load_dc2;
         ld_hit_any  <= hit_any_dc2;    // hits already need a valid load
         ld_full_hit <= full_hit_dc2;
         ld_data     <= fwd_shift[data_w-1:0];
      end
   end

endmodule

`default_nettype wire

// ==== rtl/lsu_fwd_top.sv ====
// top level of the store-to-load forwarding path
//   stage pipe, one match per older stage, merge into dc3

`default_nettype none

module lsu_fwd_top (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             op_valid,
   input  logic                             op_store,
   input  lsu_fwd_pkg::ls_size_e            op_size,
   input  logic [lsu_fwd_pkg::addr_w-1:0]   op_addr,
   input  logic [lsu_fwd_pkg::data_w-1:0]   op_wdata,
   output logic                             ld_valid,
   output logic                             ld_hit_any,
   output logic                             ld_full_hit,
   output logic [lsu_fwd_pkg::data_w-1:0]   ld_data
);
   import lsu_fwd_pkg::*;

   byteen_t           hit_lo [3];    // dc3, dc4, dc5
   byteen_t           hit_hi [3];
   logic [data_w-1:0] data_lo [3];
   logic [data_w-1:0] data_hi [3];

   lsu_stage_if dc2_if ();           // combinational
   lsu_stage_if dc3_if ();
   lsu_stage_if dc4_if ();
   lsu_stage_if dc5_if ();

   lsu_stage_pipe u_stage_pipe (
      .clk      (clk),
      .reset    (reset),
      .op_valid (op_valid),
      .op_store (op_store),
      .op_size  (op_size),
      .op_addr  (op_addr),
      .op_wdata (op_wdata),
      .dc2      (dc2_if),
      .dc3      (dc3_if),
      .dc4      (dc4_if),
      .dc5      (dc5_if)
   );

   // ********************
   // byte matches
   // ********************
   lsu_fwd_match u_match_dc3 (
      .ld (dc2_if), .st (dc3_if),
      .hit_lo (hit_lo[0]), .hit_hi (hit_hi[0]),
      .data_lo (data_lo[0]), .data_hi (data_hi[0])
   );

   lsu_fwd_match u_match_dc4 (
      .ld (dc2_if), .st (dc4_if),
      .hit_lo (hit_lo[1]), .hit_hi (hit_hi[1]),
      .data_lo (data_lo[1]), .data_hi (data_hi[1])
   );

   lsu_fwd_match u_match_dc5 (
      .ld (dc2_if), .st (dc5_if),
      .hit_lo (hit_lo[2]), .hit_hi (hit_hi[2]),
      .data_lo (data_lo[2]), .data_hi (data_hi[2])
   );

   lsu_fwd_merge u_fwd_merge (
      .clk         (clk),
      .reset       (reset),
      .ld          (dc2_if),
      .hit_lo      (hit_lo),
      .hit_hi      (hit_hi),
      .data_lo     (data_lo),
      .data_hi     (data_hi),
      .ld_valid    (ld_valid),
      .ld_hit_any  (ld_hit_any),
      .ld_full_hit (ld_full_hit),
      .ld_data     (ld_data)
   );

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
// clock and reset for the testbench
//   10 ns clock, reset high for the first 16 rising edges

`default_nettype none

module tb_clkgen (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int reset_cycles = 16;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #1 reset = 1'b0;   // released like any other input
   end

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
// checker of the forwarding path
//   model of the last three operations and the expected load result
//   output compare, per-test lines and closing counts

`default_nettype none

module tb_checker (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             op_valid,
   input  logic                             op_store,
   input  lsu_fwd_pkg::ls_size_e            op_size,
   input  logic [lsu_fwd_pkg::addr_w-1:0]   op_addr,
   input  logic [lsu_fwd_pkg::data_w-1:0]   op_wdata,
   input  logic                             ld_valid,
   input  logic                             ld_hit_any,
   input  logic                             ld_full_hit,
   input  logic [lsu_fwd_pkg::data_w-1:0]   ld_data,
   input  int                               test_id,
   input  logic                             test_end,
   input  logic                             all_done,
   output int                               err_count
);
   timeunit 1ns;
   timeprecision 100ps;
   import lsu_fwd_pkg::*;

   // index 0 is the youngest operation
   logic              h_valid [3];
   logic              h_store [3];
   logic [addr_w-1:0] h_addr  [3];
   int                h_bytes [3];
   logic [data_w-1:0] h_data  [3];

   logic              exp_valid, exp_hit_any, exp_full_hit;
   logic [data_w-1:0] exp_data;
   logic              armed = 1'b0;
   logic              summary_done = 1'b0;
   int                checks = 0;
   int                errors = 0;
   int                test_errs = 0;
   int                tests_run = 0;
   int                tests_failed = 0;

   assign err_count = errors;

   function automatic int size_bytes(input ls_size_e size);
      case (size)
         size_half: return 2;
         size_word: return 4;
         default:   return 1;
      endcase
   endfunction

   // youngest store covering each byte address supplies it
   function automatic void expected_load(
      input  logic [addr_w-1:0] addr,
      input  ls_size_e          size,
      output logic              hit_any,
      output logic              full_hit,
      output logic [data_w-1:0] data
   );
      logic [addr_w-1:0] ba;
      logic              found;
      int                off;
      hit_any  = 1'b0;
      full_hit = 1'b1;
      data     = '0;
      for (int b = 0; b < size_bytes(size); b++) begin
         ba    = addr + b;
         found = 1'b0;
         for (int s = 0; s < 3; s++) begin
            if (!found && h_valid[s] && h_store[s] &&
                ba >= h_addr[s] && ba < h_addr[s] + h_bytes[s]) begin
               off            = int'(ba - h_addr[s]);
               data[8*b +: 8] = h_data[s][8*off +: 8];
               found          = 1'b1;
            end
         end
         hit_any  = hit_any | found;
         full_hit = full_hit & found;
      end
   endfunction

   function automatic string test_name(input int id);
      case (id)
         1: return "no stores before a load";
         2: return "forwarding from each stage";
         3: return "youngest store wins";
         4: return "partial hits and sizes";
         5: return "misaligned accesses";
         default: return "random mix";
      endcase
   endfunction

   task automatic note_error();
      errors++;
      test_errs++;
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         $display("[ERROR] %0d ns: %s expected %0b, got %0b", $time, name, exp, act);
         note_error();
      end
   endtask

   task automatic compare_word(input string name, input logic [data_w-1:0] exp,
                               input logic [data_w-1:0] act);
      checks++;
      if (act !== exp) begin
         $display("[ERROR] %0d ns: %s expected %h, got %h", $time, name, exp, act);
         note_error();
      end
   endtask

   // ********************
   // model, sampled at the edge
   // ********************
   always @(posedge clk) begin
      armed = 1'b1;
      exp_hit_any  = 1'b0;
      exp_full_hit = 1'b0;
      exp_data     = '0;
      if (reset) begin
         exp_valid = 1'b0;
         for (int s = 0; s < 3; s++) h_valid[s] = 1'b0;
      end else begin
         exp_valid = op_valid & ~op_store;
         if (exp_valid)
            expected_load(op_addr, op_size, exp_hit_any, exp_full_hit, exp_data);
         for (int s = 2; s > 0; s--) begin   // age the history by one stage
            h_valid[s] = h_valid[s-1];
            h_store[s] = h_store[s-1];
            h_addr[s]  = h_addr[s-1];
            h_bytes[s] = h_bytes[s-1];
            h_data[s]  = h_data[s-1];
         end
         h_valid[0] = op_valid;
         h_store[0] = op_store;
         h_addr[0]  = op_addr;
         h_bytes[0] = size_bytes(op_size);
         h_data[0]  = op_wdata;
      end
   end

   // ********************
   // compare mid-cycle
   // ********************
   always @(negedge clk) begin
      if (armed) begin
         if (ld_valid === 1'b1 && !exp_valid) begin
            $display("%0d ns: ld_valid high one cycle after a cycle with no load", $time);
            note_error();
         end else begin
            compare_flag("ld_valid", exp_valid, ld_valid);
         end
         compare_flag("ld_hit_any", exp_hit_any, ld_hit_any);
         compare_flag("ld_full_hit", exp_full_hit, ld_full_hit);
         compare_word("ld_data", exp_data, ld_data);
      end
      if (test_end) begin
         $display("test %0d (%s): %s, %0d errors", test_id, test_name(test_id),
                  (test_errs == 0) ? "pass" : "fail", test_errs);
         tests_run++;
         if (test_errs != 0) tests_failed++;
         test_errs = 0;
      end
      if (all_done && !summary_done) begin
         $display("%0d tests, %0d failed, %0d checks, %0d errors",
                  tests_run, tests_failed, checks, errors);
         summary_done = 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_lsu_fwd.sv ====
// testbench top of the forwarding path
//   clock, DUT, checker, directed and LFSR stimulus, timeout

`default_nettype none

module tb_lsu_fwd;
   timeunit 1ns;
   timeprecision 100ps;
   import lsu_fwd_pkg::*;

   localparam int reset_cycles    = 16;
   localparam int n_random        = 2000;
   localparam int directed_cycles = 100;   // ops of tests 1 to 5
   localparam int end_cycles      = 6;     // idle tail and marker of each test
   localparam int n_tests         = 6;
   localparam int stim_cycles     = n_random + directed_cycles + n_tests * end_cycles;
   localparam int timeout_cycles  = 2 * stim_cycles + reset_cycles;
   localparam logic [15:0] lfsr_seed = 16'd4;

   logic              clk, reset;
   logic              op_valid, op_store;
   ls_size_e          op_size;
   logic [addr_w-1:0] op_addr;
   logic [data_w-1:0] op_wdata;
   logic              ld_valid, ld_hit_any, ld_full_hit;
   logic [data_w-1:0] ld_data;
   int                test_id;
   logic              test_end, all_done;
   int                err_count;
   logic [15:0]       lfsr;
   int                cycle_cnt = 0;

   tb_clkgen u_clkgen (.clk (clk), .reset (reset));

   lsu_fwd_top u_lsu_fwd_top (
      .clk (clk), .reset (reset),
      .op_valid (op_valid), .op_store (op_store), .op_size (op_size),
      .op_addr (op_addr), .op_wdata (op_wdata),
      .ld_valid (ld_valid), .ld_hit_any (ld_hit_any),
      .ld_full_hit (ld_full_hit), .ld_data (ld_data)
   );

   tb_checker u_checker (
      .clk (clk), .reset (reset),
      .op_valid (op_valid), .op_store (op_store), .op_size (op_size),
      .op_addr (op_addr), .op_wdata (op_wdata),
      .ld_valid (ld_valid), .ld_hit_any (ld_hit_any),
      .ld_full_hit (ld_full_hit), .ld_data (ld_data),
      .test_id (test_id), .test_end (test_end), .all_done (all_done),
      .err_count (err_count)
   );

   // taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic drive_op(input logic valid, input logic store, input ls_size_e size,
                           input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
      @(posedge clk);
      #1;
      op_valid = valid;
      op_store = store;
      op_size  = size;
      op_addr  = addr;
      op_wdata = data;
   endtask

   task automatic idle(input int n);
      repeat (n) drive_op(1'b0, 1'b0, size_byte, 32'h0, 32'h0);
   endtask

   task automatic end_test();
      idle(4);                 // drains the last load result
      @(posedge clk);
      #1 test_end = 1'b1;
      @(posedge clk);
      #1 test_end = 1'b0;
      test_id++;
   endtask

   task automatic random_ops(input int n);
      logic [31:0] v, st, sz, a, d;
      logic [1:0]  sz2;
      for (int i = 0; i < n; i++) begin
         rand_bits(3, v);
         rand_bits(1, st);
         rand_bits(2, sz);
         rand_bits(4, a);      // 16 byte window keeps hits common
         rand_bits(32, d);
         sz2 = (sz[1:0] == 2'd3) ? 2'd2 : sz[1:0];
         drive_op(v != 0, st[0], ls_size_e'(sz2), 32'h200 + a, d);
      end
   endtask

   // ********************
   // stimulus
   // ********************
   initial begin
      op_valid = 1'b0;
      op_store = 1'b0;
      op_size  = size_byte;
      op_addr  = '0;
      op_wdata = '0;
      test_id  = 1;
      test_end = 1'b0;
      all_done = 1'b0;
      lfsr     = lfsr_seed;
      @(negedge reset);

      drive_op(1'b1, 1'b0, size_word, 32'h100, 32'h0);
      end_test();

      for (int gap = 0; gap < 5; gap++) begin   // gaps 3 and 4 miss
         drive_op(1'b1, 1'b1, size_word, 32'h140, 32'hc0de_0000 + gap);
         idle(gap);
         drive_op(1'b1, 1'b0, size_word, 32'h140, 32'h0);
         idle(3);
      end
      end_test();

      drive_op(1'b1, 1'b1, size_byte, 32'h180, 32'h11);
      drive_op(1'b1, 1'b1, size_byte, 32'h181, 32'h22);
      drive_op(1'b1, 1'b1, size_byte, 32'h180, 32'h33);
      drive_op(1'b1, 1'b1, size_byte, 32'h182, 32'h44);
      drive_op(1'b1, 1'b0, size_word, 32'h180, 32'h0);
      idle(3);
      drive_op(1'b1, 1'b1, size_half, 32'h180, 32'haabb);
      drive_op(1'b1, 1'b1, size_byte, 32'h182, 32'hcc);
      drive_op(1'b1, 1'b1, size_byte, 32'h183, 32'hdd);
      drive_op(1'b1, 1'b0, size_word, 32'h180, 32'h0);
      idle(3);
      drive_op(1'b1, 1'b1, size_word, 32'h180, 32'h1234_5678);
      drive_op(1'b1, 1'b1, size_byte, 32'h181, 32'hee);
      drive_op(1'b1, 1'b0, size_word, 32'h180, 32'h0);
      end_test();

      drive_op(1'b1, 1'b1, size_half, 32'h1c2, 32'hbeef);
      drive_op(1'b1, 1'b0, size_word, 32'h1c0, 32'h0);
      idle(3);
      drive_op(1'b1, 1'b1, size_byte, 32'h1c1, 32'ha5);
      drive_op(1'b1, 1'b0, size_word, 32'h1c0, 32'h0);
      idle(3);
      drive_op(1'b1, 1'b1, size_word, 32'h1c0, 32'h8765_4321);
      drive_op(1'b1, 1'b0, size_byte, 32'h1c3, 32'h0);
      drive_op(1'b1, 1'b0, size_half, 32'h1c2, 32'h0);
      end_test();

      for (int off = 1; off < 4; off++) begin   // store spills into the next word
         drive_op(1'b1, 1'b1, size_word, 32'h300 + off, 32'h5a6b_7c8d + off);
         drive_op(1'b1, 1'b0, size_word, 32'h300, 32'h0);
         drive_op(1'b1, 1'b0, size_word, 32'h304, 32'h0);
         drive_op(1'b1, 1'b0, size_word, 32'h300 + off, 32'h0);
         idle(3);
      end
      end_test();

      random_ops(n_random);
      end_test();

      all_done = 1'b1;
      repeat (2) @(posedge clk);
      if (err_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // ********************
   // timeout
   // ********************
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= timeout_cycles) begin
         $display("timeout: run did not finish within %0d cycles", timeout_cycles);
         $display("Test FAILED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== src.f ====
common/lsu_fwd_pkg.sv
common/lsu_stage_if.sv
lsu_fwd/lsu_stage_pipe.sv
lsu_fwd/lsu_fwd_match.sv
lsu_fwd/lsu_fwd_merge.sv
rtl/lsu_fwd_top.sv
tb/tb_clkgen.sv
tb/tb_checker.sv
tb/tb_lsu_fwd.sv

// ==== Makefile ====
# Verilator build and run of the forwarding path testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_fwd
FILELIST  ?= src.f
BUILD_DIR ?= ./obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE) -j 0

SRCS := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then exit 1; fi
	@grep -q "Test OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
